// ==== Makefile ====
# Verilator build and run for the lane stripe buffer

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= lane_stripe_tb
FILELIST  ?= lane_stripe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/lane_stripe_consts.svh ====
//////////////////////////////////////////////////
// Lane stripe constants
// Element width, lane count and lane depth
// shared by every block of the lane buffer
//////////////////////////////////////////////////

`ifndef LANE_STRIPE_CONSTS_SVH
`define LANE_STRIPE_CONSTS_SVH

// Payload bits per element
`define LS_DATA_WIDTH   8

// Lane count, keep a power of two
`define LS_LANE_COUNT   4

// Entries per lane, keep a power of two
`define LS_LANE_DEPTH   4

// Counts 0 up to LS_LANE_DEPTH
`define LS_CREDIT_WIDTH 3

`endif

// ==== lane_stripe.f ====
+incdir+include
source/lane_stripe_pkg.sv
source/lane_fifo.sv
source/lane_distributor.sv
source/lane_merger.sv
source/lane_stripe_top.sv
sim/lane_stripe_props.sv
sim/lane_stripe_tb.sv

// ==== sim/lane_stripe_props.sv ====
//////////////////////////////////////////////////
// Lane stripe checks
// Credit and overflow assertions, bound into
// the distributor and every lane FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lane_stripe_consts.svh"

module lane_stripe_props (
  input logic                     clk_i,      // Clock
  input logic                     arst_n_i,   // Async reset, active low
  input logic                     grant_i,    // Ready on distributor, push on lane
  input logic                     blocked_i,  // No credit, or lane full
  input lane_stripe_pkg::credit_t level_i     // Credit count or lane fill
);

  import lane_stripe_pkg::*;

  // Nothing enters where there is no room
  a_no_grant_blocked: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !(grant_i && blocked_i)
  ) else $error("grant while blocked in %m");

  // Counter bounded by lane depth
  a_level_in_range: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) level_i <= credit_t'(`LS_LANE_DEPTH)
  ) else $error("level %0d above lane depth in %m", level_i);

endmodule

// Current lane credit against input ready
bind lane_distributor lane_stripe_props u_props (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .grant_i   (elem_ready_o),
  .blocked_i (credit_q[wr_lane] == '0),
  .level_i   (credit_q[wr_lane])
);

// Fill level and push against full
bind lane_fifo lane_stripe_props u_props (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .grant_i   (push_i.valid),
  .blocked_i (full),
  .level_i   (lane_stripe_pkg::credit_t'(wr_ptr - rd_ptr))
);

// ==== sim/lane_stripe_tb.sv ====
//////////////////////////////////////////////////
// Lane stripe testbench
// Table driven streams through the lane buffer,
// checked in order against a scoreboard queue
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lane_stripe_consts.svh"

module lane_stripe_tb;

  import lane_stripe_pkg::*;

  localparam int NUM_ROWS   = 4;
  localparam int RDY_ALWAYS = 0;
  localparam int RDY_LCG    = 1;
  localparam int RDY_HOLD   = 2;                                // Low for hold cycles
  localparam int FILL       = `LS_LANE_COUNT * `LS_LANE_DEPTH;  // Accepts until full

  // One test row
  typedef struct packed {
    int         count;  // Elements to send
    int         vmode;  // 0 valid always, 1 LCG gaps
    int         rmode;  // Output ready mode
    int         hold;   // Stall cycles in RDY_HOLD
    logic [7:0] start;  // First data value
    logic       lat;    // Check first element latency
  } row_t;

  logic  clk_i;
  logic  arst_n_i;
  elem_t elem_i;
  logic  elem_valid_i;
  logic  elem_ready_o;
  elem_t elem_o;
  logic  elem_valid_o;
  logic  elem_ready_i;

  row_t        rows [NUM_ROWS];
  string       names [NUM_ROWS];
  elem_t       exp_q [$];         // Accepted, not yet out
  logic [31:0] lcg_state = 32'd5;
  int          limit     = 0;     // Timeout in cycles
  int          cycles    = 0;
  int          errs      = 0;     // Current test
  int          err_total = 0;
  int          tests_run = 0;
  int          tests_bad = 0;

  lane_stripe_top UUT (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .elem_i       (elem_i),
    .elem_valid_i (elem_valid_i),
    .elem_ready_o (elem_ready_o),
    .elem_o       (elem_o),
    .elem_valid_o (elem_valid_o),
    .elem_ready_i (elem_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  // High three times in four
  function automatic logic lcg_mostly_high();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state[30:29] != 2'b00);
  endfunction

  task automatic note_fail(input string sig, input logic [31:0] exp, input logic [31:0] act);
    $display("Fail at %0t ns: %s expected %0h got %0h", $time, sig, exp, act);
    errs++;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    err_total += errs;
    if (errs == 0) begin
      $display("Test %0d %s passed", tests_run, name);
    end else begin
      tests_bad++;
      $display("Test %0d %s had %0d errors", tests_run, name, errs);
    end
    errs = 0;
  endtask

  //////////////////////////////////////////////////
  // One table row, drive and scoreboard per edge
  //////////////////////////////////////////////////

  task automatic run_row(input row_t row);
    int   sent;
    int   seen;
    int   cyc;
    int   acc_edge;
    int   pop_edge;
    bit   dropped;
    logic acc;
    logic xfer;
    sent     = 0;
    seen     = 0;
    cyc      = 0;
    acc_edge = 0;
    pop_edge = -10;
    dropped  = 1'b0;
    while (seen < row.count) begin
      @(posedge clk_i);
      cyc++;
      acc  = elem_valid_i & elem_ready_o;   // Pre edge values
      xfer = elem_valid_o & elem_ready_i;
      if (xfer) begin
        if (exp_q.size() == 0) begin
          $display("Fail at %0t ns: output element with none sent", $time);
          errs++;
        end else begin
          if (elem_o !== exp_q[0]) note_fail("elem_o", 32'(exp_q[0]), 32'(elem_o));
          void'(exp_q.pop_front());
        end
        if (seen == 0) pop_edge = cyc;
        seen++;
        if (row.lat && seen == 1 && cyc - acc_edge != 2) begin
          note_fail("elem_valid_o latency", 2, 32'(cyc - acc_edge));
        end
      end
      if (acc) begin
        exp_q.push_back(elem_i);
        if (sent == 0) acc_edge = cyc;
        sent++;
      end
      // Back pressure, fall at full and rise two cycles after first pop
      if (row.rmode == RDY_HOLD) begin
        if (!dropped && !elem_ready_o && !elem_ready_i) begin
          dropped = 1'b1;
          if (sent != FILL) note_fail("elem_ready_o accepts", FILL, 32'(sent));
        end
        if (cyc == pop_edge + 1 && elem_ready_o) note_fail("elem_ready_o", 0, 1);
        if (cyc == pop_edge + 2 && !elem_ready_o) note_fail("elem_ready_o", 1, 0);
      end
      if (acc || !elem_valid_i) begin  // Element held until taken
        if (sent < row.count && (row.vmode == 0 || lcg_mostly_high())) begin
          elem_valid_i <= 1'b1;
          elem_i.data  <= row.start + 8'(sent);
          elem_i.last  <= (sent % 8 == 7) || (sent == row.count - 1);
        end else begin
          elem_valid_i <= 1'b0;
        end
      end
      case (row.rmode)
        RDY_ALWAYS: elem_ready_i <= 1'b1;
        RDY_LCG:    elem_ready_i <= lcg_mostly_high();
        default:    elem_ready_i <= (cyc >= row.hold);
      endcase
    end
    @(posedge clk_i);
    if (elem_valid_o !== 1'b0) note_fail("elem_valid_o", 0, 32'(elem_valid_o));  // No extra
    if (exp_q.size() != 0) begin
      $display("Fail at %0t ns: %0d elements never came out", $time, exp_q.size());
      errs++;
    end
    if (row.rmode == RDY_HOLD && !dropped) begin
      $display("Fail at %0t ns: elem_ready_o never fell while output stalled", $time);
      errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int budget;
    arst_n_i     = 1'b0;
    elem_i       = '0;
    elem_valid_i = 1'b0;
    elem_ready_i = 1'b1;
    rows[0]  = '{count: 1,   vmode: 0, rmode: RDY_ALWAYS, hold: 0,  start: 8'h10, lat: 1'b1};
    rows[1]  = '{count: 40,  vmode: 0, rmode: RDY_ALWAYS, hold: 0,  start: 8'h20, lat: 1'b0};
    rows[2]  = '{count: 24,  vmode: 0, rmode: RDY_HOLD,   hold: 30, start: 8'h60, lat: 1'b0};
    rows[3]  = '{count: 200, vmode: 1, rmode: RDY_LCG,    hold: 0,  start: 8'h90, lat: 1'b0};
    names[0] = "single element latency";
    names[1] = "full rate stream";
    names[2] = "output stall";
    names[3] = "random gaps";
    budget = 100;
    foreach (rows[i]) budget += rows[i].count * 8 + rows[i].hold;
    limit = budget;
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    if (elem_valid_o !== 1'b0) note_fail("elem_valid_o", 0, 32'(elem_valid_o));
    if (elem_ready_o !== 1'b1) note_fail("elem_ready_o", 1, 32'(elem_ready_o));
    close_test("idle after reset");
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
      close_test(names[i]);
    end
    $display("%0d tests run, %0d with errors, %0d errors in all", tests_run, tests_bad,
             err_total);
    if (tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", limit);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== source/lane_distributor.sv ====
//////////////////////////////////////////////////
// Lane distributor
// Accepts the input stream and writes elements
// round robin into lanes that still have credit
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lane_stripe_consts.svh"

module lane_distributor (
  input  logic                                          clk_i,         // Clock
  input  logic                                          arst_n_i,      // Async reset
  input  lane_stripe_pkg::elem_t                        elem_i,        // Input element
  input  logic                                          elem_valid_i,  // Input valid
  output logic                                          elem_ready_o,  // Current lane has credit
  output lane_stripe_pkg::lane_push_t [`LS_LANE_COUNT-1:0] lane_push_o, // Per lane write
  input  logic [`LS_LANE_COUNT-1:0]                     credit_ret_i   // Per lane credit pulse
);

  import lane_stripe_pkg::*;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  localparam int LANE_IDX_W = $clog2(`LS_LANE_COUNT);

  credit_t [`LS_LANE_COUNT-1:0] credit_q;     // Free slots per lane
  logic [LANE_IDX_W-1:0]        wr_lane;      // Next lane to write
  logic                         has_credit;
  logic                         accept;       // Input handshake
  logic [`LS_LANE_COUNT-1:0]    take;         // One hot, lane charged this cycle

  // Push register, valid apart from payload
  logic [`LS_LANE_COUNT-1:0]    push_vld_q;
  elem_t                        push_elem_q;  // Only one lane uses it per cycle

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  assign has_credit   = (credit_q[wr_lane] != '0);
  assign elem_ready_o = has_credit;          // Never looks at valid
  assign accept       = elem_valid_i & has_credit;

  always_comb begin
    for (int i = 0; i < `LS_LANE_COUNT; i++) begin
      take[i] = accept && (wr_lane == LANE_IDX_W'(i));
    end
  end

  // Shared payload, per lane strobe
  always_comb begin
    for (int i = 0; i < `LS_LANE_COUNT; i++) begin
      lane_push_o[i].valid = push_vld_q[i];
      lane_push_o[i].elem  = push_elem_q;
    end
  end

  //////////////////////////////////////////////////
  // Credits, pointer and push strobes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `LS_LANE_COUNT; i++) begin
        credit_q[i] <= credit_t'(`LS_LANE_DEPTH);  // All lanes empty
      end
      wr_lane    <= '0;
      push_vld_q <= '0;
    end else begin
      for (int i = 0; i < `LS_LANE_COUNT; i++) begin
        unique case ({credit_ret_i[i], take[i]})
          2'b10:   credit_q[i] <= credit_q[i] + credit_t'(1);  // Returned only
          2'b01:   credit_q[i] <= credit_q[i] - credit_t'(1);  // Spent only
          default: credit_q[i] <= credit_q[i];                 // Both or none
        endcase
      end
      push_vld_q <= take;
      if (accept) begin
        wr_lane <= wr_lane + LANE_IDX_W'(1);  // Wraps, count is a power of two
      end
    end
  end

  // Payload register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      push_elem_q <= elem_i;
    end
  end

endmodule

// ==== source/lane_fifo.sv ====
//////////////////////////////////////////////////
// Lane FIFO
// One lane of the stripe buffer, pointer based
// storage with a credit pulse on every pop
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lane_stripe_consts.svh"

module lane_fifo (
  input  logic                      clk_i,         // Clock
  input  logic                      arst_n_i,      // Async reset, active low
  input  lane_stripe_pkg::lane_push_t push_i,      // Registered write from distributor
  output lane_stripe_pkg::elem_t    head_o,        // Oldest element
  output logic                      head_valid_o,  // Head present
  input  logic                      pop_i,         // Take head this edge
  output logic                      credit_ret_o   // One cycle after each pop
);

  import lane_stripe_pkg::*;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  localparam int ADDR_W = $clog2(`LS_LANE_DEPTH);

  // Storage, no reset on payload
  elem_t mem [`LS_LANE_DEPTH];

  // Extra top bit tells full from empty
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;

  logic empty;
  logic full;
  logic do_write;
  logic do_pop;
  logic credit_ret_q;

  //////////////////////////////////////////////////
  // Flags
  //////////////////////////////////////////////////

  assign empty = (wr_ptr == rd_ptr);
  // Same slot, one lap apart
  assign full  = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &&
                 (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

  // Credits keep pushes off a full lane
  assign do_write = push_i.valid & ~full;
  assign do_pop   = pop_i & ~empty;

  // Head straight from storage
  assign head_o       = mem[rd_ptr[ADDR_W-1:0]];
  assign head_valid_o = ~empty;
  assign credit_ret_o = credit_ret_q;

  //////////////////////////////////////////////////
  // Storage write
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem[wr_ptr[ADDR_W-1:0]] <= push_i.elem;  // Data and last together
    end
  end

  //////////////////////////////////////////////////
  // Pointers and credit pulse
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      credit_ret_q <= 1'b0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + (ADDR_W+1)'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + (ADDR_W+1)'(1);
      end
      credit_ret_q <= do_pop;  // Freed slot goes back to distributor
    end
  end

endmodule

// ==== source/lane_merger.sv ====
//////////////////////////////////////////////////
// Lane merger
// Drains lane heads round robin onto the output
// stream, keeping the input order
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lane_stripe_consts.svh"

module lane_merger (
  input  logic                                      clk_i,         // Clock
  input  logic                                      arst_n_i,      // Async reset
  input  lane_stripe_pkg::elem_t [`LS_LANE_COUNT-1:0] head_i,      // Lane heads
  input  logic [`LS_LANE_COUNT-1:0]                 head_valid_i,  // Lane not empty
  output logic [`LS_LANE_COUNT-1:0]                 pop_o,         // Take head
  output lane_stripe_pkg::elem_t                    elem_o,        // Output element
  output logic                                      elem_valid_o,  // Output valid
  input  logic                                      elem_ready_i   // Sink ready
);

  import lane_stripe_pkg::*;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  localparam int LANE_IDX_W = $clog2(`LS_LANE_COUNT);

  logic [LANE_IDX_W-1:0] rd_lane;  // Lane holding the oldest element
  logic                  xfer;     // Output handshake

  //////////////////////////////////////////////////
  // Output path
  //////////////////////////////////////////////////

  // Empty lane stalls, no skipping
  assign elem_o       = head_i[rd_lane];
  assign elem_valid_o = head_valid_i[rd_lane];
  assign xfer         = elem_valid_o & elem_ready_i;

  always_comb begin
    pop_o = '0;
    if (xfer) begin
      pop_o[rd_lane] = 1'b1;  // Only the lane just sent
    end
  end

  //////////////////////////////////////////////////
  // Read lane pointer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_lane <= '0;  // Same start lane as distributor
    end else if (xfer) begin
      rd_lane <= rd_lane + LANE_IDX_W'(1);
    end
  end

endmodule

// ==== source/lane_stripe_pkg.sv ====
//////////////////////////////////////////////////
// Lane stripe types
// Element, lane push and credit types
//////////////////////////////////////////////////

`include "lane_stripe_consts.svh"

package lane_stripe_pkg;

  // One element as seen on both streams
  typedef struct packed {
    logic [`LS_DATA_WIDTH-1:0] data;  // Payload
    logic                      last;  // Packet end, passed through
  } elem_t;

  // Distributor to lane write
  typedef struct packed {
    logic  valid;  // Write strobe
    elem_t elem;   // Element to store
  } lane_push_t;

  // Free entries in one lane
  typedef logic [`LS_CREDIT_WIDTH-1:0] credit_t;

endpackage

// ==== source/lane_stripe_top.sv ====
//////////////////////////////////////////////////
// Lane stripe top
// Distributor, lane FIFOs and merger
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lane_stripe_consts.svh"

module lane_stripe_top (
  input  logic                   clk_i,         // Clock
  input  logic                   arst_n_i,      // Async reset
  input  lane_stripe_pkg::elem_t elem_i,        // Input stream
  input  logic                   elem_valid_i,
  output logic                   elem_ready_o,
  output lane_stripe_pkg::elem_t elem_o,        // Output stream
  output logic                   elem_valid_o,
  input  logic                   elem_ready_i
);

  import lane_stripe_pkg::*;

  lane_push_t [`LS_LANE_COUNT-1:0] lane_push;   // Distributor to lanes
  logic [`LS_LANE_COUNT-1:0]       credit_ret;  // Lanes to distributor
  elem_t [`LS_LANE_COUNT-1:0]      head;        // Lanes to merger
  logic [`LS_LANE_COUNT-1:0]       head_valid;
  logic [`LS_LANE_COUNT-1:0]       pop;         // Merger to lanes

  lane_distributor u_distributor (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .elem_i       (elem_i),
    .elem_valid_i (elem_valid_i),
    .elem_ready_o (elem_ready_o),
    .lane_push_o  (lane_push),
    .credit_ret_i (credit_ret)
  );

  // One FIFO per lane
  for (genvar g = 0; g < `LS_LANE_COUNT; g++) begin : g_lane
    lane_fifo u_lane (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .push_i       (lane_push[g]),
      .head_o       (head[g]),
      .head_valid_o (head_valid[g]),
      .pop_i        (pop[g]),
      .credit_ret_o (credit_ret[g])
    );
  end

  lane_merger u_merger (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .head_i       (head),
    .head_valid_i (head_valid),
    .pop_o        (pop),
    .elem_o       (elem_o),
    .elem_valid_o (elem_valid_o),
    .elem_ready_i (elem_ready_i)
  );

endmodule
